// File: Bender.yml
package:
  name: parityRam

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - parityRamPkg.sv
      - bramPrimitive.sv
      - bramBasicInst.sv
      - parityEncoder.sv
      - parityChecker.sv
      - parityRam.sv
  - target: test
    include_dirs:
      - .
    files:
      - parityRam_props.sv
      - parityRamTb.sv

// File: bramBasicInst.sv
// basic wrapper around the dual-port primitive
// takes 36-bit words with parity in the top bits, splits them for the
// primitive and joins the read words back as {parity, data}
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module bramBasicInst
	import parityRamPkg::*;
(
	input logic clk,
	input logic reset,
	// port A
	input logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] wdA,
	output logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] rdA,
	input addrT adrsA,
	input logic ckeA,
	input byteEnT wCkeA,
	// port B
	input logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] wdB,
	output logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] rdB,
	input addrT adrsB,
	input logic ckeB,
	input byteEnT wCkeB
);

	// write side split
	dataT wdAData;
	parityT wdAParity;
	dataT wdBData;
	parityT wdBParity;
	// read side from the primitive
	dataT rdAData;
	parityT rdAParity;
	dataT rdBData;
	parityT rdBParity;

	assign wdAData = wdA[`RAM_DATA_WIDTH-1:0];
	assign wdAParity = wdA[`RAM_DATA_WIDTH+`RAM_BYTES-1:`RAM_DATA_WIDTH];
	assign wdBData = wdB[`RAM_DATA_WIDTH-1:0];
	assign wdBParity = wdB[`RAM_DATA_WIDTH+`RAM_BYTES-1:`RAM_DATA_WIDTH];

	// parity above data on the way out
	assign rdA = {rdAParity, rdAData};
	assign rdB = {rdBParity, rdBData};

	bramPrimitive #(
		.pWriteFirst (`RAM_WRITE_FIRST)
	) i_bramPrimitive (
		.clk (clk),
		.reset (reset),
		.wdA (wdAData),
		.wdpA (wdAParity),
		.adrsA (adrsA),
		.ckeA (ckeA),
		.wCkeA (wCkeA),
		.rdA (rdAData),
		.rdpA (rdAParity),
		.wdB (wdBData),
		.wdpB (wdBParity),
		.adrsB (adrsB),
		.ckeB (ckeB),
		.wCkeB (wCkeB),
		.rdB (rdBData),
		.rdpB (rdBParity)
	);

endmodule

// File: bramPrimitive.sv
// behavioral model of a true dual-port block RAM primitive
// data and parity live in separate arrays, writes are per byte,
// each port registers its read word when its clock enable is high
// instantiate through the basic wrapper rather than directly
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module bramPrimitive
	import parityRamPkg::*;
#(
	// 0 read-first, 1 write-first
	parameter bit pWriteFirst = 1'b0
)(
	input logic clk,
	input logic reset,
	// port A
	input dataT wdA,
	input parityT wdpA,
	input addrT adrsA,
	input logic ckeA,
	input byteEnT wCkeA,
	output dataT rdA,
	output parityT rdpA,
	// port B
	input dataT wdB,
	input parityT wdpB,
	input addrT adrsB,
	input logic ckeB,
	input byteEnT wCkeB,
	output dataT rdB,
	output parityT rdpB
);

	localparam int ramDepth = 1 << `RAM_ADDR_WIDTH;

	// storage starts cleared, no init file
	dataT memData [ramDepth] = '{default: '0};
	parityT memParity [ramDepth] = '{default: '0};

	// word as it looks after this cycle's byte writes
	function automatic dataT mergeData(input dataT oldWord, input dataT newWord,
		input byteEnT en);
		dataT merged;
		merged = oldWord;
		for (int i = 0; i < `RAM_BYTES; i++) begin
			if (en[i]) begin
				merged[i*8 +: 8] = newWord[i*8 +: 8];
			end
		end
		return merged;
	endfunction

	// same merge for the parity bits
	function automatic parityT mergeParity(input parityT oldPar, input parityT newPar,
		input byteEnT en);
		return (oldPar & ~en) | (newPar & en);
	endfunction

	// byte writes, port B applied last on a shared address
	always_ff @(posedge clk) begin
		for (int i = 0; i < `RAM_BYTES; i++) begin
			if (ckeA && wCkeA[i]) begin
				memData[adrsA][i*8 +: 8] <= wdA[i*8 +: 8];
				memParity[adrsA][i] <= wdpA[i];
			end
			if (ckeB && wCkeB[i]) begin
				memData[adrsB][i*8 +: 8] <= wdB[i*8 +: 8];
				memParity[adrsB][i] <= wdpB[i];
			end
		end
	end

	// output registers
	always_ff @(posedge clk) begin
		if (reset) begin
			rdA <= '0;
			rdpA <= '0;
			rdB <= '0;
			rdpB <= '0;
		end else begin
			if (ckeA) begin
				// write-first shows the new bytes, read-first the old word
				if (pWriteFirst) begin
					rdA <= mergeData(memData[adrsA], wdA, wCkeA);
					rdpA <= mergeParity(memParity[adrsA], wdpA, wCkeA);
				end else begin
					rdA <= memData[adrsA];
					rdpA <= memParity[adrsA];
				end
			end
			if (ckeB) begin
				if (pWriteFirst) begin
					rdB <= mergeData(memData[adrsB], wdB, wCkeB);
					rdpB <= mergeParity(memParity[adrsB], wdpB, wCkeB);
				end else begin
					rdB <= memData[adrsB];
					rdpB <= memParity[adrsB];
				end
			end
		end
	end

endmodule

// File: parityChecker.sv
// read side of the parity RAM
// forwards a strobed read address straight to port B, then checks the
// returned word one cycle later by recomputing the byte parity
// rdValid comes two cycles after rdStrobe, one read per cycle at most
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module parityChecker
	import parityRamPkg::*;
(
	input logic clk,
	input logic reset,
	input logic rdStrobe,
	input addrT rdAddr,
	// port B read word, {parity, data}
	input logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] ramWord,
	output addrT ramAddr,
	output logic ramCke,
	output logic rdValid,
	output rdRespT rdResp
);

	// word split into its fields
	dataT wordData;
	parityT wordParity;
	// high while the primitive output holds a requested word
	logic wordValid;

	assign wordData = ramWord[`RAM_DATA_WIDTH-1:0];
	assign wordParity = ramWord[`RAM_DATA_WIDTH+`RAM_BYTES-1:`RAM_DATA_WIDTH];

	// address goes out in the strobe cycle
	assign ramAddr = rdAddr;
	assign ramCke = rdStrobe;

	// two stage valid pipeline
	always_ff @(posedge clk) begin
		if (reset) begin
			wordValid <= 1'b0;
			rdValid <= 1'b0;
		end else begin
			// stage one, primitive has registered the word
			wordValid <= rdStrobe;
			// stage two, result registered below
			rdValid <= wordValid;
		end
	end

	// result capture
	always_ff @(posedge clk) begin
		if (wordValid) begin
			rdResp.data <= wordData;
			// mismatch of stored against recomputed parity
			rdResp.parityError <= wordParity ^ byteParity(wordData);
		end
	end

endmodule

// File: parityEncoder.sv
// write side of the parity RAM
// registers each strobed write request, adds even parity per byte
// and flips the parity bits chosen by the injection mask
// outputs drive port A of the RAM wrapper one cycle after the strobe
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module parityEncoder
	import parityRamPkg::*;
(
	input logic clk,
	input logic reset,
	input logic wrStrobe,
	input wrReqT wrReq,
	output logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] ramWord,
	output addrT ramAddr,
	output logic ramCke,
	output byteEnT ramByteEn
);

	// parity as it will be stored, errors injected here
	parityT storedParity;

	assign storedParity = byteParity(wrReq.data) ^ wrReq.injectMask;

	// control, one cycle per strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			ramCke <= 1'b0;
			ramByteEn <= '0;
		end else begin
			ramCke <= wrStrobe;
			// no stray byte writes between requests
			ramByteEn <= wrStrobe ? wrReq.byteEn : '0;
		end
	end

	// payload, only loaded on a strobe
	always_ff @(posedge clk) begin
		if (wrStrobe) begin
			ramAddr <= wrReq.addr;
			ramWord <= {storedParity, wrReq.data};
		end
	end

endmodule

// File: parityRam.f
+incdir+.
parityRamPkg.sv
bramPrimitive.sv
bramBasicInst.sv
parityEncoder.sv
parityChecker.sv
parityRam.sv
parityRam_props.sv
parityRamTb.sv

// File: parityRam.sv
// top level of the parity protected block RAM
// port A of the RAM takes writes from the encoder, port B serves
// reads through the checker, both on one clock
// writes and reads are single-cycle strobes without back-pressure,
// read results follow two cycles after rdStrobe
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module parityRam
	import parityRamPkg::*;
(
	input logic clk,
	input logic reset,
	// write request
	input logic wrStrobe,
	input wrReqT wrReq,
	// read request and response
	input logic rdStrobe,
	input addrT rdAddr,
	output logic rdValid,
	output rdRespT rdResp
);

	// port A, encoder to RAM
	logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] wrWord;
	addrT wrAddr;
	logic wrCke;
	byteEnT wrByteEn;
	// port B, checker to RAM and back
	logic [`RAM_DATA_WIDTH+`RAM_BYTES-1:0] rdWord;
	addrT rdRamAddr;
	logic rdCke;

	parityEncoder i_parityEncoder (
		.clk (clk),
		.reset (reset),
		.wrStrobe (wrStrobe),
		.wrReq (wrReq),
		.ramWord (wrWord),
		.ramAddr (wrAddr),
		.ramCke (wrCke),
		.ramByteEn (wrByteEn)
	);

	// port A write only, port B read only
	bramBasicInst i_bramBasicInst (
		.clk (clk),
		.reset (reset),
		.wdA (wrWord),
		.rdA (),
		.adrsA (wrAddr),
		.ckeA (wrCke),
		.wCkeA (wrByteEn),
		.wdB ('0),
		.rdB (rdWord),
		.adrsB (rdRamAddr),
		.ckeB (rdCke),
		.wCkeB ('0)
	);

	parityChecker i_parityChecker (
		.clk (clk),
		.reset (reset),
		.rdStrobe (rdStrobe),
		.rdAddr (rdAddr),
		.ramWord (rdWord),
		.ramAddr (rdRamAddr),
		.ramCke (rdCke),
		.rdValid (rdValid),
		.rdResp (rdResp)
	);

endmodule

// File: parityRamPkg.sv
// shared types for the parity protected block RAM
// modules pull these in with a wildcard import in their header,
// widths come from the settings header
`include "parityRam_settings.svh"

package parityRamPkg;

	// word address into the array
	typedef logic [`RAM_ADDR_WIDTH-1:0] addrT;
	// data field of one word
	typedef logic [`RAM_DATA_WIDTH-1:0] dataT;
	// one even parity bit per byte
	typedef logic [`RAM_BYTES-1:0] parityT;
	// per-byte write enables
	typedef logic [`RAM_BYTES-1:0] byteEnT;

	// write request from the outside
	typedef struct packed {
		addrT addr;
		dataT data;
		byteEnT byteEn;
		// set bits flip the stored parity of that byte
		parityT injectMask;
	} wrReqT;

	// read response back to the outside
	typedef struct packed {
		dataT data;
		// one bit per byte whose check failed
		parityT parityError;
	} rdRespT;

	// even parity of each byte, bit i covers data[8*i+7:8*i]
	function automatic parityT byteParity(input dataT data);
		parityT par;
		for (int i = 0; i < `RAM_BYTES; i++) begin
			par[i] = ^data[i*8 +: 8];
		end
		return par;
	endfunction

endpackage

// File: parityRamTb.sv
// testbench for the parity RAM
// runs a directed table of writes and reads, a back-to-back read burst
// and an LFSR driven random phase, all against a local model
// inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/100ps
`include "parityRam_settings.svh"

module parityRamTb
	import parityRamPkg::*;
();

	localparam int timeoutCycles = 20;
	localparam int randomWrites = 16;
	localparam int numSteps = 15;

	// one directed step, expected fields only used on reads
	typedef struct packed {
		logic isWrite;
		addrT addr;
		dataT data;
		byteEnT byteEn;
		parityT inject;
		dataT expData;
		parityT expErr;
	} stepT;

	// wr  addr     data           be    inj   expData        expErr
	stepT steps [numSteps] = '{
		'{1'b0, 10'h3ff, 32'h0000_0000, 4'h0, 4'h0, 32'h0000_0000, 4'h0},
		'{1'b1, 10'h010, 32'h1234_5678, 4'hf, 4'h0, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h010, 32'h0000_0000, 4'h0, 4'h0, 32'h1234_5678, 4'h0},
		'{1'b1, 10'h010, 32'haabb_ccdd, 4'h5, 4'h0, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h010, 32'h0000_0000, 4'h0, 4'h0, 32'h12bb_56dd, 4'h0},
		'{1'b1, 10'h020, 32'hdead_beef, 4'hf, 4'h9, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h020, 32'h0000_0000, 4'h0, 4'h0, 32'hdead_beef, 4'h9},
		'{1'b1, 10'h020, 32'h1100_0022, 4'h9, 4'h0, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h020, 32'h0000_0000, 4'h0, 4'h0, 32'h11ad_be22, 4'h0},
		'{1'b1, 10'h030, 32'hffff_ffff, 4'hf, 4'h2, 32'h0000_0000, 4'h0},
		'{1'b1, 10'h030, 32'h0000_0000, 4'h1, 4'h0, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h030, 32'h0000_0000, 4'h0, 4'h0, 32'hffff_ff00, 4'h2},
		'{1'b1, 10'h3ff, 32'h0f0f_0f0f, 4'hf, 4'hf, 32'h0000_0000, 4'h0},
		'{1'b0, 10'h3ff, 32'h0000_0000, 4'h0, 4'h0, 32'h0f0f_0f0f, 4'hf},
		'{1'b0, 10'h010, 32'h0000_0000, 4'h0, 4'h0, 32'h12bb_56dd, 4'h0}
	};

	logic clk;
	logic reset;
	logic wrStrobe;
	wrReqT wrReq;
	logic rdStrobe;
	addrT rdAddr;
	logic rdValid;
	rdRespT rdResp;

	// model, data plus the injected error mask per word
	dataT modelData [1 << `RAM_ADDR_WIDTH];
	parityT modelErr [1 << `RAM_ADDR_WIDTH];
	logic [31:0] lfsrState = 32'hb0eb_926b;
	int checkCount = 0;
	int errorCount = 0;
	int testCount = 0;

	parityRam i_dut (
		.clk (clk),
		.reset (reset),
		.wrStrobe (wrStrobe),
		.wrReq (wrReq),
		.rdStrobe (rdStrobe),
		.rdAddr (rdAddr),
		.rdValid (rdValid),
		.rdResp (rdResp)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic checkValue(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1, one step per bit taken
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
			bits = {bits[30:0], lfsrState[0]};
		end
		return bits;
	endfunction

	// enabled bytes take new data, their error bit follows the mask
	task automatic modelWrite(input addrT addr, input dataT data, input byteEnT be,
		input parityT inj);
		for (int i = 0; i < `RAM_BYTES; i++) begin
			if (be[i]) begin
				modelData[addr][i*8 +: 8] = data[i*8 +: 8];
				modelErr[addr][i] = inj[i];
			end
		end
	endtask

	task automatic writeWord(input addrT addr, input dataT data, input byteEnT be,
		input parityT inj);
		@(posedge clk);
		wrStrobe <= 1'b1;
		wrReq.addr <= addr;
		wrReq.data <= data;
		wrReq.byteEn <= be;
		wrReq.injectMask <= inj;
		@(posedge clk);
		wrStrobe <= 1'b0;
		modelWrite(addr, data, be, inj);
	endtask

	// single read, waits for rdValid with a bound
	task automatic readCheck(input addrT addr, input dataT expData, input parityT expErr);
		int waited;
		@(posedge clk);
		rdStrobe <= 1'b1;
		rdAddr <= addr;
		@(posedge clk);
		rdStrobe <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (!rdValid && waited < timeoutCycles) begin
			@(negedge clk);
			waited++;
		end
		if (!rdValid) begin
			errorCount++;
			$display("no rdValid within %0d cycles of the read at %h", timeoutCycles, addr);
		end else begin
			checkValue("rdResp.data", expData, rdResp.data);
			checkValue("rdResp.parityError", expErr, rdResp.parityError);
		end
	endtask

	// four reads in consecutive cycles, results must come back to back
	task automatic burstRead();
		addrT addrs [4];
		int waited;
		addrs = '{10'h010, 10'h020, 10'h030, 10'h3ff};
		fork
			begin
				foreach (addrs[i]) begin
					@(posedge clk);
					rdStrobe <= 1'b1;
					rdAddr <= addrs[i];
				end
				@(posedge clk);
				rdStrobe <= 1'b0;
			end
			begin
				waited = 0;
				@(negedge clk);
				while (!rdValid && waited < timeoutCycles) begin
					@(negedge clk);
					waited++;
				end
				if (!rdValid) begin
					errorCount++;
					$display("no rdValid within %0d cycles of the burst", timeoutCycles);
				end else begin
					foreach (addrs[i]) begin
						checkValue("rdResp.data", modelData[addrs[i]], rdResp.data);
						checkValue("rdResp.parityError", modelErr[addrs[i]],
							rdResp.parityError);
						@(negedge clk);
						// pulse train holds until the last read, then ends
						checkValue("rdValid", i < $size(addrs) - 1, rdValid);
					end
				end
			end
		join
	endtask

	task automatic randomPhase();
		addrT addr;
		addrT written [$];
		for (int n = 0; n < randomWrites; n++) begin
			addr = addrT'(randomBits(`RAM_ADDR_WIDTH));
			writeWord(addr, dataT'(randomBits(32)), byteEnT'(randomBits(`RAM_BYTES)),
				parityT'(randomBits(`RAM_BYTES)));
			written.push_back(addr);
		end
		// last write must land before the first read
		repeat (2) @(posedge clk);
		foreach (written[i]) begin
			readCheck(written[i], modelData[written[i]], modelErr[written[i]]);
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			$display("test %0d %s: ok", testCount, name);
		end else begin
			$display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
		end
	endtask

	initial begin
		int errorsBefore;
		foreach (modelData[i]) begin
			modelData[i] = '0;
			modelErr[i] = '0;
		end
		reset = 1'b1;
		wrStrobe = 1'b0;
		wrReq = '0;
		rdStrobe = 1'b0;
		rdAddr = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;

		// idle after reset, nothing comes out
		errorsBefore = errorCount;
		repeat (3) begin
			@(negedge clk);
			checkValue("rdValid", 0, rdValid);
		end
		reportTest("idle after reset", errorsBefore);

		// directed table, writes get two idle cycles before anything else
		foreach (steps[i]) begin
			errorsBefore = errorCount;
			if (steps[i].isWrite) begin
				writeWord(steps[i].addr, steps[i].data, steps[i].byteEn, steps[i].inject);
				repeat (2) @(posedge clk);
				reportTest($sformatf("write %h", steps[i].addr), errorsBefore);
			end else begin
				readCheck(steps[i].addr, steps[i].expData, steps[i].expErr);
				reportTest($sformatf("read %h", steps[i].addr), errorsBefore);
			end
		end

		errorsBefore = errorCount;
		burstRead();
		reportTest("back-to-back reads", errorsBefore);

		errorsBefore = errorCount;
		randomPhase();
		reportTest("random writes and reads", errorsBefore);

		errorCount += i_dut.i_props.assertFails;
		$display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// File: parityRam_props.sv
// protocol assertions for the parity RAM top level
// bound into every parityRam instance, watches the read side only
`timescale 1ns/100ps

module parityRamProps
	import parityRamPkg::*;
(
	input logic clk,
	input logic reset,
	input logic rdStrobe,
	input logic rdValid,
	input rdRespT rdResp
);

	// number of failed assertions so far
	int assertFails = 0;

	// result exactly two cycles after each strobe, never otherwise
	assert property (@(posedge clk) disable iff (reset)
		rdValid == $past(rdStrobe, 2))
	else begin
		assertFails++;
		$error("rdValid not aligned two cycles after rdStrobe");
	end

	// quiet during reset and the cycle after it
	assert property (@(posedge clk)
		reset |=> !rdValid ##1 !rdValid)
	else begin
		assertFails++;
		$error("rdValid high during or right after reset");
	end

	// no X or Z on a valid response
	assert property (@(posedge clk) disable iff (reset)
		rdValid |-> !$isunknown(rdResp))
	else begin
		assertFails++;
		$error("rdResp has unknown bits while rdValid is high");
	end

endmodule

bind parityRam parityRamProps i_props (
	.clk (clk),
	.reset (reset),
	.rdStrobe (rdStrobe),
	.rdValid (rdValid),
	.rdResp (rdResp)
);

// File: parityRam_settings.svh
// build-time settings for the parity protected block RAM
// include this ahead of the package and in every RTL file that sizes
// a port or a loop from these values
`ifndef PARITYRAM_SETTINGS_SVH
`define PARITYRAM_SETTINGS_SVH

// word address width, 10 bits gives 1024 words
`define RAM_ADDR_WIDTH 10

// data bits per word, parity bits ride alongside
`define RAM_DATA_WIDTH 32

// bytes per word, also one even parity bit per byte
`define RAM_BYTES 4

// 0 selects read-first, 1 selects write-first on both ports
`define RAM_WRITE_FIRST 0

`endif
